// ==== sim.f ====
+incdir+common
common/ecc_pkg.sv
ecc/extended_hamming_encoder.sv
ecc/extended_hamming_corrector.sv
hw/ecc_storage.sv
hw/apb_ecc_regs.sv
hw/ecc_mem_top.sv
sim/tb_ecc_mem.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_ecc_mem, check $(LOG)"
	@echo "  clean  remove build output and log"

test:
	verilator --binary -Wno-fatal -f sim.f --top-module tb_ecc_mem \
		--Mdir obj_dir -o tb_ecc_mem
	-./obj_dir/tb_ecc_mem > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "Test failed"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "Test did not complete"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/tb_ecc_mem.sv ====
`include "ecc_macros.svh"

module tb_ecc_mem;

  timeunit 1ns;
  timeprecision 1ps;

  import ecc_pkg::*;

  // Cycles allowed for pready before an access is declared stuck
  localparam int READY_LIMIT = 20;
  localparam int N_RANDOM    = 24;

  // One table row is a write with optional injection and then a read back
  typedef struct {
    ecc_addr_t idx;
    ecc_data_t wdata;
    ecc_data_t inj_d;
    ecc_code_t inj_c;
    ecc_data_t exp_data;
    bit        exp_cor;
    bit        exp_unc;
    ecc_pos_t  exp_pos;
  } case_t;

  logic                           clk;
  logic                           rst;
  logic                           psel;
  logic                           penable;
  logic                           pwrite;
  logic [`ECC_APB_ADDR_WIDTH-1:0] paddr;
  ecc_data_t                      pwdata;
  ecc_data_t                      prdata;
  logic                           pready;
  logic                           pslverr;

  case_t    cases[$];
  ecc_cnt_t corr_model;
  ecc_cnt_t uncorr_model;
  integer   seed;
  // Access cycles with pready low in the last transfer
  int       last_waits;

  ecc_mem_top u_dut (
    .clk     ( clk     ),
    .rst     ( rst     ),
    .psel    ( psel    ),
    .penable ( penable ),
    .pwrite  ( pwrite  ),
    .paddr   ( paddr   ),
    .pwdata  ( pwdata  ),
    .prdata  ( prdata  ),
    .pready  ( pready  ),
    .pslverr ( pslverr )
  );

  always #20 clk = ~clk;

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input ecc_data_t got, input ecc_data_t exp, input string name);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH at time %0t: %s got 0x%h expected 0x%h",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_pos(input ecc_pos_t got, input ecc_pos_t exp, input string name);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH at time %0t: %s got %0d expected %0d",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_cnt(input ecc_cnt_t got, input ecc_cnt_t exp, input string name);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH at time %0t: %s got %0d expected %0d",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input bit got, input bit exp, input string name);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH at time %0t: %s got %0b expected %0b",
                               $time, name, got, exp));
    end
  endtask

  // Memory reads stall one cycle and every other access none
  task automatic check_waits(input int exp, input string name);
    if (last_waits != exp) begin
      report_failure($sformatf("MISMATCH at time %0t: %s wait states got %0d expected %0d",
                               $time, name, last_waits, exp));
    end
  endtask

  // Data bit i takes the i-th position that is neither 0 nor a power of two
  function automatic ecc_pos_t data_bit_pos(input int i);
    int pos;
    int seen;
    pos  = 2;
    seen = -1;
    while (seen < i) begin
      pos++;
      if ($countones(pos) != 1) seen++;
    end
    return ecc_pos_t'(pos);
  endfunction

  // Code bit 0 sits at position 0 and code bit k at 2**(k-1)
  function automatic ecc_pos_t code_bit_pos(input int k);
    return (k == 0) ? ecc_pos_t'(0) : ecc_pos_t'(1 << (k - 1));
  endfunction

  // Byte address of a word in the memory window
  function automatic logic [`ECC_APB_ADDR_WIDTH-1:0] word_addr(input ecc_addr_t idx);
    return `ECC_MEM_BASE + `ECC_APB_ADDR_WIDTH'(4 * idx);
  endfunction

  // Uncorrectable words come back exactly as stored
  function automatic case_t make_case(input ecc_addr_t idx, input ecc_data_t wdata,
                                      input ecc_data_t inj_d, input ecc_code_t inj_c,
                                      input bit cor, input bit unc, input ecc_pos_t pos);
    case_t c;
    c.idx      = idx;
    c.wdata    = wdata;
    c.inj_d    = inj_d;
    c.inj_c    = inj_c;
    c.exp_data = unc ? (wdata ^ inj_d) : wdata;
    c.exp_cor  = cor;
    c.exp_unc  = unc;
    c.exp_pos  = pos;
    return c;
  endfunction

  // Setup on one falling edge and access on the next until pready
  task automatic apb_xfer(input bit wr, input logic [`ECC_APB_ADDR_WIDTH-1:0] addr,
                          input ecc_data_t wdata, output ecc_data_t rdata, output bit err);
    int waited;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    waited  = 0;
    while (pready !== 1'b1) begin
      if (waited >= READY_LIMIT) begin
        report_failure($sformatf("Timeout: no pready within %0d cycles on access to 0x%h",
                                 READY_LIMIT, addr));
      end
      @(negedge clk);
      waited++;
    end
    last_waits = waited;
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Register accesses and memory writes complete without a wait state
  task automatic reg_write(input logic [`ECC_APB_ADDR_WIDTH-1:0] addr, input ecc_data_t wdata);
    ecc_data_t rd;
    bit        err;
    apb_xfer(1'b1, addr, wdata, rd, err);
    check_flag(err, 1'b0, "pslverr");
    check_waits(0, "pready");
  endtask

  task automatic reg_read(input logic [`ECC_APB_ADDR_WIDTH-1:0] addr, output ecc_data_t rdata);
    bit err;
    apb_xfer(1'b0, addr, '0, rdata, err);
    check_flag(err, 1'b0, "pslverr");
    check_waits(0, "pready");
  endtask

  // STATUS fields of the last memory read
  task automatic check_status(input bit cor, input bit unc, input ecc_pos_t pos);
    ecc_data_t st;
    reg_read(`ECC_REG_STATUS, st);
    check_flag(st[0], cor, "status.correctable");
    check_flag(st[1], unc, "status.uncorrectable");
    check_pos(st[13:8], pos, "status.position");
  endtask

  task automatic check_counters();
    ecc_data_t v;
    reg_read(`ECC_REG_CORR_CNT, v);
    check_cnt(v[15:0], corr_model, "corr_cnt");
    reg_read(`ECC_REG_UNCORR_CNT, v);
    check_cnt(v[15:0], uncorr_model, "uncorr_cnt");
  endtask

  // Arm the masks, write the word, read it back through the corrector
  task automatic run_case(input case_t c);
    ecc_data_t rd;
    bit        err;
    if (c.inj_d != '0) reg_write(`ECC_REG_INJ_DATA, c.inj_d);
    if (c.inj_c != '0) reg_write(`ECC_REG_INJ_CODE, ecc_data_t'(c.inj_c));
    reg_write(word_addr(c.idx), c.wdata);
    apb_xfer(1'b0, word_addr(c.idx), '0, rd, err);
    check_waits(1, "pready");
    check_data(rd, c.exp_data, "prdata");
    check_flag(err, c.exp_unc, "pslverr");
    if (c.exp_cor) corr_model++;
    if (c.exp_unc) uncorr_model++;
    check_status(c.exp_cor, c.exp_unc, c.exp_pos);
    check_counters();
  endtask

  initial begin
    ecc_data_t rd;
    bit        err;
    int        b;
    clk          = 1'b0;
    rst          = 1'b1;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    corr_model   = '0;
    uncorr_model = '0;
    last_waits   = 0;
    seed         = 32'hed8dec1b;

    // Clean words
    cases.push_back(make_case(4'd0, 32'hdeadbeef, '0, '0, 0, 0, '0));
    cases.push_back(make_case(4'd5, 32'h00000000, '0, '0, 0, 0, '0));
    cases.push_back(make_case(4'd9, 32'hffffffff, '0, '0, 0, 0, '0));
    cases.push_back(make_case(4'd15, 32'h12345678, '0, '0, 0, 0, '0));
    // Single data flips
    cases.push_back(make_case(4'd3, 32'ha5a5a5a5, 32'h1, '0, 1, 0, data_bit_pos(0)));
    cases.push_back(make_case(4'd7, 32'h0f0f0f0f, 32'h1 << 17, '0, 1, 0, data_bit_pos(17)));
    cases.push_back(make_case(4'd12, 32'h80000001, 32'h1 << 31, '0, 1, 0, data_bit_pos(31)));
    // Single flips of a Hamming check bit and of the overall bit
    cases.push_back(make_case(4'd1, 32'hcafef00d, '0, 7'h1 << 3, 1, 0, code_bit_pos(3)));
    cases.push_back(make_case(4'd2, 32'h13579bdf, '0, 7'h1 << 6, 1, 0, code_bit_pos(6)));
    cases.push_back(make_case(4'd4, 32'h2468ace0, '0, 7'h1, 1, 0, code_bit_pos(0)));
    // Double flips
    cases.push_back(make_case(4'd6, 32'h55aa55aa, 32'h00100004, '0, 0, 1, '0));
    cases.push_back(make_case(4'd8, 32'h0badc0de, 32'h20, 7'h1 << 2, 0, 1, '0));
    cases.push_back(make_case(4'd10, 32'h76543210, '0, 7'h03, 0, 1, '0));
    // Random words with one random flip anywhere in the block
    for (int n = 0; n < N_RANDOM; n++) begin
      rd = $random(seed);
      b  = {$random(seed)} % `ECC_BLOCK_WIDTH;
      if (b < `ECC_CODE_WIDTH) begin
        cases.push_back(make_case(ecc_addr_t'(n), rd, '0, ecc_code_t'(1 << b), 1, 0,
                                  code_bit_pos(b)));
      end else begin
        cases.push_back(make_case(ecc_addr_t'(n), rd, 32'h1 << (b - 7), '0, 1, 0,
                                  data_bit_pos(b - 7)));
      end
    end

    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    check_counters();
    foreach (cases[i]) begin
      run_case(cases[i]);
    end

    // Any value written to CORR_CNT clears both
    reg_write(`ECC_REG_CORR_CNT, 32'h5a);
    corr_model   = '0;
    uncorr_model = '0;
    check_counters();

    // Unmapped offsets including one past the word window and a misaligned one
    apb_xfer(1'b1, 12'h014, 32'hffffffff, rd, err);
    check_flag(err, 1'b1, "pslverr");
    apb_xfer(1'b0, word_addr(4'd15) + 12'h4, '0, rd, err);
    check_flag(err, 1'b1, "pslverr");
    check_waits(0, "pready");
    apb_xfer(1'b1, 12'h102, 32'h1, rd, err);
    check_flag(err, 1'b1, "pslverr");
    reg_read(`ECC_REG_INJ_DATA, rd);
    check_data(rd, '0, "inj_data");
    check_counters();

    // Masks are spent on the first write only
    reg_write(`ECC_REG_INJ_DATA, 32'h1 << 9);
    reg_write(word_addr(4'd2), 32'h600dcafe);
    reg_read(`ECC_REG_INJ_DATA, rd);
    check_data(rd, '0, "inj_data");
    reg_write(word_addr(4'd2), 32'h600dcafe);
    apb_xfer(1'b0, word_addr(4'd2), '0, rd, err);
    check_waits(1, "pready");
    check_data(rd, 32'h600dcafe, "prdata");
    check_flag(err, 1'b0, "pslverr");
    check_status(1'b0, 1'b0, '0);
    check_counters();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== hw/ecc_mem_top.sv ====
`include "ecc_macros.svh"

module ecc_mem_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [`ECC_APB_ADDR_WIDTH-1:0] paddr,
  input  ecc_pkg::ecc_data_t             pwdata,
  output ecc_pkg::ecc_data_t             prdata,
  output logic                           pready,
  output logic                           pslverr
);

  import ecc_pkg::*;

  // Register block to array
  logic      mem_we;
  logic      mem_re;
  ecc_addr_t mem_addr;
  ecc_data_t mem_wdata;
  ecc_data_t inj_data;
  ecc_code_t inj_code;

  // Encoder output for the write word
  ecc_code_t wr_code;

  // Array read port to the corrector
  ecc_data_t rd_data;
  ecc_code_t rd_code;

  // Corrector results back to the register block
  ecc_data_t corr_data;
  ecc_pos_t  corr_pos;
  logic      correctable;
  logic      uncorrectable;

  apb_ecc_regs regs (
    .clk           ( clk           ),
    .rst           ( rst           ),
    .psel          ( psel          ),
    .penable       ( penable       ),
    .pwrite        ( pwrite        ),
    .paddr         ( paddr         ),
    .pwdata        ( pwdata        ),
    .prdata        ( prdata        ),
    .pready        ( pready        ),
    .pslverr       ( pslverr       ),
    .corr_data     ( corr_data     ),
    .corr_pos      ( corr_pos      ),
    .correctable   ( correctable   ),
    .uncorrectable ( uncorrectable ),
    .mem_we        ( mem_we        ),
    .mem_re        ( mem_re        ),
    .mem_addr      ( mem_addr      ),
    .mem_wdata     ( mem_wdata     ),
    .inj_data      ( inj_data      ),
    .inj_code      ( inj_code      )
  );

  // Check bits come from the clean word, faults are added in the array
  extended_hamming_encoder encoder (
    .data ( mem_wdata ),
    .code ( wr_code   )
  );

  ecc_storage storage (
    .clk      ( clk       ),
    .we       ( mem_we    ),
    .re       ( mem_re    ),
    .addr     ( mem_addr  ),
    .wdata    ( mem_wdata ),
    .wcode    ( wr_code   ),
    .inj_data ( inj_data  ),
    .inj_code ( inj_code  ),
    .rdata    ( rd_data   ),
    .rcode    ( rd_code   )
  );

  extended_hamming_corrector corrector (
    .data                     ( rd_data       ),
    .code                     ( rd_code       ),
    .corrected_data           ( corr_data     ),
    .corrected_error_position ( corr_pos      ),
    .correctable_error        ( correctable   ),
    .uncorrectable_error      ( uncorrectable )
  );

endmodule

// ==== hw/apb_ecc_regs.sv ====
`include "ecc_macros.svh"

module apb_ecc_regs (
  input  logic                              clk,
  input  logic                              rst,
  // APB slave
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [`ECC_APB_ADDR_WIDTH-1:0]    paddr,
  input  ecc_pkg::ecc_data_t                pwdata,
  output ecc_pkg::ecc_data_t                prdata,
  output logic                              pready,
  output logic                              pslverr,
  // Corrector results for the word being read
  input  ecc_pkg::ecc_data_t                corr_data,
  input  ecc_pkg::ecc_pos_t                 corr_pos,
  input  logic                              correctable,
  input  logic                              uncorrectable,
  // Memory side
  output logic                              mem_we,
  output logic                              mem_re,
  output ecc_pkg::ecc_addr_t                mem_addr,
  output ecc_pkg::ecc_data_t                mem_wdata,
  output ecc_pkg::ecc_data_t                inj_data,
  output ecc_pkg::ecc_code_t                inj_code
);

  import ecc_pkg::*;

  localparam int ADDR_W = $bits(ecc_addr_t);
  localparam int POS_W  = $bits(ecc_pos_t);
  // Byte span of the word window
  localparam logic [`ECC_APB_ADDR_WIDTH-1:0] MEM_SPAN = `ECC_APB_ADDR_WIDTH'(4 * `ECC_DEPTH);

  apb_state_t state;

  // Address decode
  logic [`ECC_APB_ADDR_WIDTH-1:0] mem_off;
  logic       is_mem;
  logic       reg_hit;
  ecc_addr_t  mem_idx;
  ecc_data_t  reg_val;

  // Registered read data and error for zero wait transfers
  ecc_data_t  prdata_q;
  logic       err_q;
  // Second access cycle of a memory read
  logic       read_done;

  // Result of the last memory read
  logic       st_cor;
  logic       st_unc;
  ecc_pos_t   st_pos;

  ecc_cnt_t   corr_cnt;
  ecc_cnt_t   uncorr_cnt;

  // Word window check, word aligned only
  assign mem_off = paddr - `ECC_MEM_BASE;
  assign is_mem  = (paddr >= `ECC_MEM_BASE) && (mem_off < MEM_SPAN) && (paddr[1:0] == 2'b00);
  assign mem_idx = mem_off[2 +: ADDR_W];

  // Register read mux, reg_hit low on any unmapped offset
  always_comb begin
    reg_val = '0;
    reg_hit = 1'b1;
    case (paddr)
      `ECC_REG_STATUS: begin
        reg_val[0]            = st_cor;
        reg_val[1]            = st_unc;
        reg_val[8 +: POS_W]   = st_pos;
      end
      `ECC_REG_CORR_CNT:   reg_val = ecc_data_t'(corr_cnt);
      `ECC_REG_UNCORR_CNT: reg_val = ecc_data_t'(uncorr_cnt);
      `ECC_REG_INJ_DATA:   reg_val = inj_data;
      `ECC_REG_INJ_CODE:   reg_val = ecc_data_t'(inj_code);
      default:             reg_hit = 1'b0;
    endcase
  end

  // Transfer FSM and control registers
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= idle;
      pready     <= 1'b0;
      err_q      <= 1'b0;
      read_done  <= 1'b0;
      mem_we     <= 1'b0;
      mem_re     <= 1'b0;
      st_cor     <= 1'b0;
      st_unc     <= 1'b0;
      st_pos     <= '0;
      corr_cnt   <= '0;
      uncorr_cnt <= '0;
      inj_data   <= '0;
      inj_code   <= '0;
    end else begin
      // Strobes last one cycle
      mem_we <= 1'b0;
      mem_re <= 1'b0;
      case (state)
        idle: begin
          // Setup phase, decide the access cycle now
          if (psel && !penable) begin
            if (is_mem && !pwrite) begin
              // Array read during the first access cycle, pready stays low
              mem_re <= 1'b1;
              err_q  <= 1'b0;
              state  <= read_wait;
            end else begin
              pready <= 1'b1;
              err_q  <= !(is_mem || reg_hit);
              mem_we <= is_mem && pwrite;
              state  <= access;
            end
          end
        end
        read_wait: begin
          // Block is in the read register after this edge
          pready    <= 1'b1;
          read_done <= 1'b1;
          state     <= access;
        end
        access: begin
          pready    <= 1'b0;
          read_done <= 1'b0;
          state     <= idle;
          if (read_done) begin
            // Memory read completes, log the outcome
            st_cor <= correctable;
            st_unc <= uncorrectable;
            st_pos <= corr_pos;
            if (correctable && (corr_cnt != '1)) begin
              corr_cnt <= corr_cnt + 1'b1;
            end
            if (uncorrectable && (uncorr_cnt != '1)) begin
              uncorr_cnt <= uncorr_cnt + 1'b1;
            end
          end else if (mem_we) begin
            // Masks are spent on this write
            inj_data <= '0;
            inj_code <= '0;
          end else if (pwrite && reg_hit) begin
            case (paddr)
              // Any value clears both counters
              `ECC_REG_CORR_CNT: begin
                corr_cnt   <= '0;
                uncorr_cnt <= '0;
              end
              `ECC_REG_INJ_DATA: inj_data <= pwdata;
              `ECC_REG_INJ_CODE: inj_code <= pwdata[$bits(ecc_code_t)-1:0];
              // STATUS and UNCORR_CNT are read only
              default: ;
            endcase
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Payload captured at setup
  always_ff @(posedge clk) begin
    if (state == idle && psel && !penable) begin
      prdata_q  <= reg_val;
      mem_addr  <= mem_idx;
      mem_wdata <= pwdata;
    end
  end

  // Memory reads return the corrector output directly
  assign prdata  = read_done ? corr_data : prdata_q;
  assign pslverr = read_done ? uncorrectable : err_q;

endmodule

// ==== hw/ecc_storage.sv ====
`include "ecc_macros.svh"

module ecc_storage (
  input  logic               clk,
  input  logic               we,
  input  logic               re,
  input  ecc_pkg::ecc_addr_t addr,
  input  ecc_pkg::ecc_data_t wdata,
  input  ecc_pkg::ecc_code_t wcode,
  input  ecc_pkg::ecc_data_t inj_data,
  input  ecc_pkg::ecc_code_t inj_code,
  output ecc_pkg::ecc_data_t rdata,
  output ecc_pkg::ecc_code_t rcode
);

  import ecc_pkg::*;

  localparam int DATA_W  = `ECC_DATA_WIDTH;
  localparam int BLOCK_W = `ECC_BLOCK_WIDTH;

  // Stored as {code, data}, Hamming order only matters to the codec
  logic [BLOCK_W-1:0] mem [`ECC_DEPTH];

  // Word and code after fault injection
  ecc_data_t          wr_data_flt;
  ecc_code_t          wr_code_flt;

  // Read register feeding the corrector
  logic [BLOCK_W-1:0] rd_block;

  // Set mask bits flip the stored copy
  // Zero masks give a clean write
  assign wr_data_flt = wdata ^ inj_data;
  assign wr_code_flt = wcode ^ inj_code;

  // Write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= {wr_code_flt, wr_data_flt};
    end
  end

  // Registered read port
  // Block appears one cycle after re and holds until the next read
  always_ff @(posedge clk) begin
    if (re) begin
      rd_block <= mem[addr];
    end
  end

  // Split the block back into its two fields
  assign rdata = rd_block[DATA_W-1:0];
  assign rcode = rd_block[BLOCK_W-1:DATA_W];

endmodule

// ==== ecc/extended_hamming_corrector.sv ====
`include "ecc_macros.svh"

module extended_hamming_corrector (
  input  ecc_pkg::ecc_data_t data,
  input  ecc_pkg::ecc_code_t code,
  output ecc_pkg::ecc_data_t corrected_data,
  output ecc_pkg::ecc_pos_t  corrected_error_position,
  output logic               correctable_error,
  output logic               uncorrectable_error
);

  import ecc_pkg::*;

  localparam int BLOCK_W = `ECC_BLOCK_WIDTH;
  localparam int HAM_W   = `ECC_CODE_WIDTH - 1;

  // Received block in Hamming order
  logic [BLOCK_W-1:0] block;
  // Same block after the single-bit fix
  logic [BLOCK_W-1:0] fixed_block;
  logic [BLOCK_W-1:0] flip_mask;
  ecc_pos_t           syndrome;
  logic               parity_odd;
  // Syndrome names a real bit of the block
  logic               in_range;

  // Rebuild the block from the stored word and check bits
  always_comb begin
    int unsigned d;
    int unsigned c;
    block = '0;
    d = 0;
    c = 1;
    block[0] = code[0];
    for (int p = 1; p < BLOCK_W; p++) begin
      if ((p & (p - 1)) == 0) begin
        block[p] = code[c];
        c++;
      end else begin
        block[p] = data[d];
        d++;
      end
    end
  end

  // Syndrome bit k sums every position with index bit k set
  // A single flip leaves the flipped index here
  always_comb begin
    syndrome = '0;
    for (int k = 0; k < HAM_W; k++) begin
      for (int p = 1; p < BLOCK_W; p++) begin
        if (((p >> k) & 1) == 1) begin
          syndrome[k] = syndrome[k] ^ block[p];
        end
      end
    end
  end

  assign parity_odd = ^block;
  assign in_range   = syndrome < BLOCK_W;

  // Odd parity means an odd number of flips, taken as one
  // Syndrome 0 with odd parity is the overall bit itself
  // An index past the block end can only come from three or more flips
  assign correctable_error = parity_odd && in_range;

  // Even parity with a nonzero syndrome is a double flip
  assign uncorrectable_error = (!parity_odd && (syndrome != '0)) ||
                               (parity_odd && !in_range);

  assign corrected_error_position = correctable_error ? syndrome : '0;

  // One-hot at the faulty position, empty when nothing is fixed
  assign flip_mask   = correctable_error ? ({{(BLOCK_W-1){1'b0}}, 1'b1} << syndrome) : '0;
  assign fixed_block = block ^ flip_mask;

  // Gather the data back out of the non power of two positions
  always_comb begin
    int unsigned d;
    corrected_data = '0;
    d = 0;
    for (int p = 1; p < BLOCK_W; p++) begin
      if ((p & (p - 1)) != 0) begin
        corrected_data[d] = fixed_block[p];
        d++;
      end
    end
  end

endmodule

// ==== ecc/extended_hamming_encoder.sv ====
`include "ecc_macros.svh"

module extended_hamming_encoder (
  input  ecc_pkg::ecc_data_t data,
  output ecc_pkg::ecc_code_t code
);

  localparam int BLOCK_W = `ECC_BLOCK_WIDTH;
  localparam int HAM_W   = `ECC_CODE_WIDTH - 1;

  // Block with the check positions left at zero
  logic [BLOCK_W-1:0] block;
  // Hamming bits, ham[k] sits at block position 2**k
  logic [HAM_W-1:0]   ham;
  logic               overall;

  // Scatter the data over the non power of two positions
  // Position 0 and the powers of two stay clear here
  always_comb begin
    int unsigned d;
    block = '0;
    d = 0;
    for (int p = 1; p < BLOCK_W; p++) begin
      if ((p & (p - 1)) != 0) begin
        block[p] = data[d];
        d++;
      end
    end
  end

  // Each check bit evens out the positions carrying its index bit
  // Check positions are zero in block so they drop out of the sum
  always_comb begin
    ham = '0;
    for (int k = 0; k < HAM_W; k++) begin
      for (int p = 1; p < BLOCK_W; p++) begin
        if (((p >> k) & 1) == 1) begin
          ham[k] = ham[k] ^ block[p];
        end
      end
    end
  end

  // Overall bit makes the complete block even
  assign overall = ^{ham, data};

  // code[0] is position 0, code[k+1] is position 2**k
  assign code = {ham, overall};

endmodule

// ==== common/ecc_pkg.sv ====
`include "ecc_macros.svh"

package ecc_pkg;

  // Payload word as seen on the bus and in the array
  typedef logic [`ECC_DATA_WIDTH-1:0] ecc_data_t;

  // Check bits, bit 0 is the overall parity
  typedef logic [`ECC_CODE_WIDTH-1:0] ecc_code_t;

  // Bit index inside the 39-bit Hamming block
  typedef logic [$clog2(`ECC_BLOCK_WIDTH)-1:0] ecc_pos_t;

  // Word index into the array
  typedef logic [$clog2(`ECC_DEPTH)-1:0] ecc_addr_t;

  // Correction and detection counters
  typedef logic [`ECC_CNT_WIDTH-1:0] ecc_cnt_t;

  // APB transfer FSM
  // read_wait covers the extra cycle of a memory read
  typedef enum logic [1:0] {
    idle,
    access,
    read_wait
  } apb_state_t;

endpackage

// ==== common/ecc_macros.svh ====
`ifndef ECC_MACROS_SVH
`define ECC_MACROS_SVH

// One protected word per memory location
`define ECC_DATA_WIDTH 32

// 6 Hamming bits plus the overall parity bit
`define ECC_CODE_WIDTH 7

// Stored block is the word and its check bits side by side
`define ECC_BLOCK_WIDTH (`ECC_DATA_WIDTH + `ECC_CODE_WIDTH)

// Number of words in the array
`define ECC_DEPTH 16

// Saturating error counters
`define ECC_CNT_WIDTH 16

// APB byte address
`define ECC_APB_ADDR_WIDTH 12

// Register map, byte offsets
`define ECC_REG_STATUS     12'h000
`define ECC_REG_CORR_CNT   12'h004
`define ECC_REG_UNCORR_CNT 12'h008
`define ECC_REG_INJ_DATA   12'h00C
`define ECC_REG_INJ_CODE   12'h010
// Words live at base + 4 * index
`define ECC_MEM_BASE       12'h100

`endif
